/* design/dacMonitor.sv */
// selects are static inputs sampled every clock; any code above FILTER0 shows the metric
`timescale 1ns/1ps
`include "detector_settings.svh"

module dacMonitor import detectorPkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          sym2xEn,
  input  iqSample_t     sample,
  input  iqSample_t     filt0,
  input  logic          filtValid,
  input  symbolResult_t result,
  input  logic          symEnOut,
  input  logic [3:0]    dac0Select,
  input  logic [3:0]    dac1Select,
  input  logic [3:0]    dac2Select,
  output dacPort_t      dac0,
  output dacPort_t      dac1,
  output dacPort_t      dac2
);

  // ------------------------------------------------------------
  // monitor sources, each with its own strobe
  // ------------------------------------------------------------
  dacPort_t srcI;
  dacPort_t srcQ;
  dacPort_t srcMetric;
  dacPort_t srcFilter0;

  assign srcI       = '{sync: sym2xEn, data: sample.i};
  assign srcQ       = '{sync: sym2xEn, data: sample.q};
  // metric left justified in the dac word
  assign srcMetric  = '{sync: symEnOut, data: {result.metric, 10'b0}};
  assign srcFilter0 = '{sync: filtValid, data: filt0.i};

  // select decoder shared by all three channels
  function automatic dacPort_t pickSource(input logic [3:0] sel);
    case (sel)
      `DAC_SEL_I:       return srcI;
      `DAC_SEL_Q:       return srcQ;
      `DAC_SEL_FILTER0: return srcFilter0;
      `DAC_SEL_METRIC:  return srcMetric;
      default:          return srcMetric;
    endcase
  endfunction

  // ------------------------------------------------------------
  // output registers
  // ------------------------------------------------------------
  // one clock behind the source
  // data keeps its last value through reset
  always_ff @(posedge clk) begin
    if (reset) begin
      dac0.sync <= 1'b0;
      dac1.sync <= 1'b0;
      dac2.sync <= 1'b0;
    end else begin
      dac0 <= pickSource(dac0Select);
      dac1 <= pickSource(dac1Select);
      dac2 <= pickSource(dac2Select);
    end
  end

endmodule

/* design/detectorPkg.sv */
// struct widths follow detector_settings.svh; first member listed is the most significant field
`include "detector_settings.svh"

package detectorPkg;

  // complex sample, i in the upper half
  typedef struct packed {
    logic signed [`SAMPLE_WIDTH-1:0] i;
    logic signed [`SAMPLE_WIDTH-1:0] q;
  } iqSample_t;

  // one dac monitor channel
  // sync marks a new data value
  typedef struct packed {
    logic                     sync;
    logic [`SAMPLE_WIDTH-1:0] data;
  } dacPort_t;

  // hard decision plus saturated soft metric
  // positive metric means tone 1 is stronger
  typedef struct packed {
    logic                            decision;
    logic signed [`METRIC_WIDTH-1:0] metric;
  } symbolResult_t;

endpackage

/* design/detector_settings.svh */
// assumes 18-bit two's complement I/Q and Q1.17 coefficients; select codes above 3 fall back
`ifndef DETECTOR_SETTINGS_SVH
`define DETECTOR_SETTINGS_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------
`define SAMPLE_WIDTH    18
`define COEF_FRAC       17
`define MAG_WIDTH       36
`define METRIC_WIDTH    8
// energy difference to soft metric scaling
`define METRIC_SHIFT    22
`define METRIC_MAX      127

// ------------------------------------------------------------
// dac monitor select codes
// ------------------------------------------------------------
`define DAC_SEL_I       4'd0
`define DAC_SEL_Q       4'd1
`define DAC_SEL_METRIC  4'd2
`define DAC_SEL_FILTER0 4'd3

// filter 0, order is tap0 re, tap0 im, tap1 re, tap1 im
`define F0_C0RE 18'h1B48C
`define F0_C0IM 18'h10B85
`define F0_C1RE 18'h3D7D4
`define F0_C1IM 18'h1FE6B
// filter 1, conjugate tone of filter 0
`define F1_C0RE 18'h1B48C
`define F1_C0IM 18'h2F47B
`define F1_C1RE 18'h3D7D4
`define F1_C1IM 18'h20195

`endif

/* design/dualFilterDetector.sv */
// no carrier loop, input must be frequency-locked; fixed 3-cycle latency from symEn to symEnOut
`timescale 1ns/1ps
`include "detector_settings.svh"

module dualFilterDetector import detectorPkg::*; (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            symEn,
  input  logic                            sym2xEn,
  input  iqSample_t                       sample,
  input  logic [3:0]                      dac0Select,
  input  logic [3:0]                      dac1Select,
  input  logic [3:0]                      dac2Select,
  output logic                            decision,
  output logic signed [`METRIC_WIDTH-1:0] metric,
  output logic                            symEnOut,
  output logic                            sym2xEnOut,
  output dacPort_t                        dac0,
  output dacPort_t                        dac1,
  output dacPort_t                        dac2
);

  iqSample_t     filt0;
  iqSample_t     filt1;
  logic          filtValid;
  symbolResult_t result;

  // ------------------------------------------------------------
  // matched filters, one per tone
  // ------------------------------------------------------------
  matchedFilter #(
    .c0Re(`F0_C0RE), .c0Im(`F0_C0IM), .c1Re(`F0_C1RE), .c1Im(`F0_C1IM)
  ) u_filter0 (
    .clk(clk), .reset(reset), .sym2xEn(sym2xEn), .symEn(symEn),
    .sample(sample), .filtered(filt0), .filtValid(filtValid)
  );

  // valid matches filter 0 cycle for cycle, left open
  matchedFilter #(
    .c0Re(`F1_C0RE), .c0Im(`F1_C0IM), .c1Re(`F1_C1RE), .c1Im(`F1_C1IM)
  ) u_filter1 (
    .clk(clk), .reset(reset), .sym2xEn(sym2xEn), .symEn(symEn),
    .sample(sample), .filtered(filt1), .filtValid()
  );

  // ------------------------------------------------------------
  // energy comparison and strobes
  // ------------------------------------------------------------
  energyCompare u_energyCompare (
    .clk(clk), .reset(reset), .filterValid(filtValid),
    .filt0(filt0), .filt1(filt1), .result(result),
    .symEnOut(symEnOut), .sym2xEnOut(sym2xEnOut)
  );

  assign decision = result.decision;
  assign metric   = result.metric;

  // debug dac channels
  dacMonitor u_dacMonitor (
    .clk(clk), .reset(reset), .sym2xEn(sym2xEn), .sample(sample),
    .filt0(filt0), .filtValid(filtValid), .result(result), .symEnOut(symEnOut),
    .dac0Select(dac0Select), .dac1Select(dac1Select), .dac2Select(dac2Select),
    .dac0(dac0), .dac1(dac1), .dac2(dac2)
  );

endmodule

/* design/energyCompare.sv */
// filterValid pulses must be at least 3 cycles apart for the 2-cycle line-decoder strobe
`timescale 1ns/1ps
`include "detector_settings.svh"

module energyCompare import detectorPkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          filterValid,
  input  iqSample_t     filt0,
  input  iqSample_t     filt1,
  output symbolResult_t result,
  output logic          symEnOut,
  output logic          sym2xEnOut
);

  // one extra bit so the energy difference keeps its sign
  localparam int diffWidth = `MAG_WIDTH + 1;
  localparam logic signed [diffWidth-1:0] metricMax = `METRIC_MAX;
  localparam logic signed [diffWidth-1:0] metricMin = -`METRIC_MAX;

  logic signed [2*`SAMPLE_WIDTH-1:0] sq0I;
  logic signed [2*`SAMPLE_WIDTH-1:0] sq0Q;
  logic signed [2*`SAMPLE_WIDTH-1:0] sq1I;
  logic signed [2*`SAMPLE_WIDTH-1:0] sq1Q;

  logic [`MAG_WIDTH-1:0] mag0;
  logic [`MAG_WIDTH-1:0] mag1;
  logic                  magValid;

  logic signed [diffWidth-1:0]     magDiff;
  logic signed [diffWidth-1:0]     magDiffShift;
  logic signed [`METRIC_WIDTH-1:0] metricNext;
  logic                            symEnDly;

  // ------------------------------------------------------------
  // stage 1, energy per filter
  // ------------------------------------------------------------
  // squares are never negative, at most 2^34 each
  assign sq0I = filt0.i * filt0.i;
  assign sq0Q = filt0.q * filt0.q;
  assign sq1I = filt1.i * filt1.i;
  assign sq1Q = filt1.q * filt1.q;

  // sum reaches 2^35, fits unsigned MAG_WIDTH
  always_ff @(posedge clk) begin
    if (filterValid) begin
      mag0 <= unsigned'(sq0I) + unsigned'(sq0Q);
      mag1 <= unsigned'(sq1I) + unsigned'(sq1Q);
    end
  end

  // ------------------------------------------------------------
  // stage 2, decision and soft metric
  // ------------------------------------------------------------
  assign magDiff      = $signed({1'b0, mag1}) - $signed({1'b0, mag0});
  assign magDiffShift = magDiff >>> `METRIC_SHIFT;

  // symmetric clip, -128 never produced
  always_comb begin
    if (magDiffShift > metricMax) begin
      metricNext = metricMax[`METRIC_WIDTH-1:0];
    end else if (magDiffShift < metricMin) begin
      metricNext = metricMin[`METRIC_WIDTH-1:0];
    end else begin
      metricNext = magDiffShift[`METRIC_WIDTH-1:0];
    end
  end

  // result holds until the next symbol
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else if (magValid) begin
      result.decision <= (mag0 < mag1);
      result.metric   <= metricNext;
    end
  end

  // ------------------------------------------------------------
  // strobes
  // ------------------------------------------------------------
  // symEnOut lands 2 cycles after filterValid
  // sym2xEnOut stretched over the 2 cycles after symEnOut
  always_ff @(posedge clk) begin
    if (reset) begin
      magValid   <= 1'b0;
      symEnOut   <= 1'b0;
      symEnDly   <= 1'b0;
      sym2xEnOut <= 1'b0;
    end else begin
      magValid   <= filterValid;
      symEnOut   <= magValid;
      symEnDly   <= symEnOut;
      sym2xEnOut <= symEnOut | symEnDly;
    end
  end

endmodule

/* design/matchedFilter.sv */
// needs symEn only on the second sample of a symbol; output truncates by COEF_FRAC, then saturates
`timescale 1ns/1ps
`include "detector_settings.svh"

module matchedFilter import detectorPkg::*; #(
  parameter logic signed [`SAMPLE_WIDTH-1:0] c0Re = `F0_C0RE,
  parameter logic signed [`SAMPLE_WIDTH-1:0] c0Im = `F0_C0IM,
  parameter logic signed [`SAMPLE_WIDTH-1:0] c1Re = `F0_C1RE,
  parameter logic signed [`SAMPLE_WIDTH-1:0] c1Im = `F0_C1IM
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      sym2xEn,
  input  logic      symEn,
  input  iqSample_t sample,
  output iqSample_t filtered,
  output logic      filtValid
);

  // four products of 2*SAMPLE_WIDTH bits need two guard bits
  localparam int accWidth = 2 * `SAMPLE_WIDTH + 2;
  localparam logic signed [accWidth-1:0] satMax = (2 ** (`SAMPLE_WIDTH - 1)) - 1;
  localparam logic signed [accWidth-1:0] satMin = -(2 ** (`SAMPLE_WIDTH - 1));

  iqSample_t firstSample;

  logic signed [accWidth-1:0] accRe;
  logic signed [accWidth-1:0] accIm;
  logic signed [accWidth-1:0] accReShift;
  logic signed [accWidth-1:0] accImShift;

  // clip a shifted sum back into one sample word
  function automatic logic signed [`SAMPLE_WIDTH-1:0] saturate(
    input logic signed [accWidth-1:0] value
  );
    if (value > satMax) begin
      return satMax[`SAMPLE_WIDTH-1:0];
    end else if (value < satMin) begin
      return satMin[`SAMPLE_WIDTH-1:0];
    end
    return value[`SAMPLE_WIDTH-1:0];
  endfunction

  // ------------------------------------------------------------
  // first sample of the symbol
  // ------------------------------------------------------------
  // held until the second sample arrives with symEn
  always_ff @(posedge clk) begin
    if (sym2xEn && !symEn) begin
      firstSample <= sample;
    end
  end

  // ------------------------------------------------------------
  // complex taps, full precision
  // ------------------------------------------------------------
  // re = c0re*x0i - c0im*x0q + c1re*x1i - c1im*x1q
  assign accRe = c0Re * firstSample.i - c0Im * firstSample.q
               + c1Re * sample.i - c1Im * sample.q;
  // im = c0re*x0q + c0im*x0i + c1re*x1q + c1im*x1i
  assign accIm = c0Re * firstSample.q + c0Im * firstSample.i
               + c1Re * sample.q + c1Im * sample.i;

  // drop the coefficient fraction, rounds toward minus infinity
  assign accReShift = accRe >>> `COEF_FRAC;
  assign accImShift = accIm >>> `COEF_FRAC;

  // ------------------------------------------------------------
  // output register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (symEn) begin
      filtered.i <= saturate(accReShift);
      filtered.q <= saturate(accImShift);
    end
  end

  // one-cycle valid, one clock after symEn
  always_ff @(posedge clk) begin
    if (reset) begin
      filtValid <= 1'b0;
    end else begin
      filtValid <= symEn;
    end
  end

endmodule

/* sim/detector_checker.sv */
// models track the DUT from its ports only; assumes symEn on second samples, at least 4 cycles apart
`timescale 1ns/1ps
`include "detector_settings.svh"

module detector_checker import detectorPkg::*; (
  input logic                            clk,
  input logic                            reset,
  input logic                            symEn,
  input logic                            sym2xEn,
  input iqSample_t                       sample,
  input logic [3:0]                      dac0Select,
  input logic [3:0]                      dac1Select,
  input logic [3:0]                      dac2Select,
  input logic                            decision,
  input logic signed [`METRIC_WIDTH-1:0] metric,
  input logic                            symEnOut,
  input logic                            sym2xEnOut,
  input dacPort_t                        dac0,
  input dacPort_t                        dac1,
  input dacPort_t                        dac2
);

  localparam longint sampleMax = (2 ** (`SAMPLE_WIDTH - 1)) - 1;
  localparam longint sampleMin = -(2 ** (`SAMPLE_WIDTH - 1));
  localparam longint coefF0 [4] = '{longint'($signed(`F0_C0RE)), longint'($signed(`F0_C0IM)),
                                    longint'($signed(`F0_C1RE)), longint'($signed(`F0_C1IM))};
  localparam longint coefF1 [4] = '{longint'($signed(`F1_C0RE)), longint'($signed(`F1_C0IM)),
                                    longint'($signed(`F1_C1RE)), longint'($signed(`F1_C1IM))};

  // read by the testbench at the end of the run
  int errorCount = 0;

  iqSample_t     firstHold;
  iqSample_t     f0Now;
  iqSample_t     f1Now;
  iqSample_t     f0Model;
  symbolResult_t resultNow;
  symbolResult_t resultStage;
  symbolResult_t heldResult;
  // bit n is symEn delayed n+1 cycles
  logic [4:0]    validD;
  logic          seenSymEn;
  dacPort_t      expNow0;
  dacPort_t      expNow1;
  dacPort_t      expNow2;
  dacPort_t      expQ0;
  dacPort_t      expQ1;
  dacPort_t      expQ2;

  function automatic longint clip(input longint value, input longint lo, input longint hi);
    if (value > hi) return hi;
    if (value < lo) return lo;
    return value;
  endfunction

  // y = c0*x0 + c1*x1, complex, then drop the fraction and clip
  function automatic iqSample_t filterModel(input iqSample_t x0, input iqSample_t x1,
                                            input longint c [4]);
    longint re;
    longint im;
    longint clipped;
    iqSample_t y;
    re = c[0] * longint'(x0.i) - c[1] * longint'(x0.q)
       + c[2] * longint'(x1.i) - c[3] * longint'(x1.q);
    im = c[0] * longint'(x0.q) + c[1] * longint'(x0.i)
       + c[2] * longint'(x1.q) + c[3] * longint'(x1.i);
    clipped = clip(re >>> `COEF_FRAC, sampleMin, sampleMax);
    y.i = clipped[`SAMPLE_WIDTH-1:0];
    clipped = clip(im >>> `COEF_FRAC, sampleMin, sampleMax);
    y.q = clipped[`SAMPLE_WIDTH-1:0];
    return y;
  endfunction

  function automatic longint energy(input iqSample_t y);
    return longint'(y.i) * longint'(y.i) + longint'(y.q) * longint'(y.q);
  endfunction

  // tone 1 stronger gives decision 1 and a positive metric
  function automatic symbolResult_t decide(input iqSample_t y0, input iqSample_t y1);
    longint shifted;
    symbolResult_t r;
    shifted = clip((energy(y1) - energy(y0)) >>> `METRIC_SHIFT, -`METRIC_MAX, `METRIC_MAX);
    r.decision = energy(y0) < energy(y1);
    r.metric = shifted[`METRIC_WIDTH-1:0];
    return r;
  endfunction

  // unknown codes show the metric
  function automatic dacPort_t expectedChannel(input logic [3:0] sel, input iqSample_t smp,
                                               input logic smpSync, input iqSample_t f0,
                                               input logic f0Sync, input symbolResult_t res,
                                               input logic resSync);
    if (sel == `DAC_SEL_I) return '{sync: smpSync, data: smp.i};
    if (sel == `DAC_SEL_Q) return '{sync: smpSync, data: smp.q};
    if (sel == `DAC_SEL_FILTER0) return '{sync: f0Sync, data: f0.i};
    return '{sync: resSync, data: {res.metric, 10'b0}};
  endfunction

  // ------------------------------------------------------------
  // reference pipeline
  // ------------------------------------------------------------
  always_comb begin
    f0Now = filterModel(firstHold, sample, coefF0);
    f1Now = filterModel(firstHold, sample, coefF1);
    resultNow = decide(f0Now, f1Now);
    expNow0 = expectedChannel(dac0Select, sample, sym2xEn, f0Model, validD[0], heldResult,
                              validD[2]);
    expNow1 = expectedChannel(dac1Select, sample, sym2xEn, f0Model, validD[0], heldResult,
                              validD[2]);
    expNow2 = expectedChannel(dac2Select, sample, sym2xEn, f0Model, validD[0], heldResult,
                              validD[2]);
  end

  always_ff @(posedge clk) begin
    if (sym2xEn && !symEn) firstHold <= sample;
    if (symEn) begin
      f0Model     <= f0Now;
      resultStage <= resultNow;
    end
    if (reset) begin
      validD     <= '0;
      seenSymEn  <= 1'b0;
      heldResult <= '0;
      expQ0      <= '0;
      expQ1      <= '0;
      expQ2      <= '0;
    end else begin
      validD <= {validD[3:0], symEn};
      if (symEn) seenSymEn <= 1'b1;
      // lands together with the 3-cycle symEnOut
      if (validD[1]) heldResult <= resultStage;
      expQ0 <= expNow0;
      expQ1 <= expNow1;
      expQ2 <= expNow2;
    end
  end

  // ------------------------------------------------------------
  // assertions
  // ------------------------------------------------------------
  a_quietAfterReset: assert property (@(posedge clk) disable iff (reset)
    !seenSymEn |-> !(symEnOut || sym2xEnOut || dac0.sync || dac1.sync || dac2.sync))
    else begin
      errorCount++;
      $error("a strobe or DAC sync went high before the first symEn at t=%0t", $time);
    end

  a_symEnOut: assert property (@(posedge clk) disable iff (reset) symEnOut == validD[2])
    else begin
      errorCount++;
      $error("ERROR t=%0t symEnOut expected %0b actual %0b", $time, $sampled(validD[2]),
             $sampled(symEnOut));
    end

  a_decision: assert property (@(posedge clk) disable iff (reset)
    validD[2] |-> decision == heldResult.decision)
    else begin
      errorCount++;
      $error("ERROR t=%0t decision expected %0b actual %0b", $time,
             $sampled(heldResult.decision), $sampled(decision));
    end

  a_metric: assert property (@(posedge clk) disable iff (reset)
    validD[2] |-> metric == heldResult.metric)
    else begin
      errorCount++;
      $error("ERROR t=%0t metric expected %0d actual %0d", $time,
             $sampled(heldResult.metric), $sampled(metric));
    end

  // high 4 and 5 cycles after symEn, never else
  a_sym2xEnOut: assert property (@(posedge clk) disable iff (reset)
    sym2xEnOut == (validD[3] || validD[4]))
    else begin
      errorCount++;
      $error("ERROR t=%0t sym2xEnOut expected %0b actual %0b", $time,
             $sampled(validD[3] || validD[4]), $sampled(sym2xEnOut));
    end

  // data only compared while sync is expected
  a_dac0: assert property (@(posedge clk) disable iff (reset)
    dac0.sync == expQ0.sync && (!expQ0.sync || dac0.data == expQ0.data))
    else begin
      errorCount++;
      $error("ERROR t=%0t dac0 expected %h actual %h", $time, $sampled(expQ0), $sampled(dac0));
    end

  a_dac1: assert property (@(posedge clk) disable iff (reset)
    dac1.sync == expQ1.sync && (!expQ1.sync || dac1.data == expQ1.data))
    else begin
      errorCount++;
      $error("ERROR t=%0t dac1 expected %h actual %h", $time, $sampled(expQ1), $sampled(dac1));
    end

  a_dac2: assert property (@(posedge clk) disable iff (reset)
    dac2.sync == expQ2.sync && (!expQ2.sync || dac2.data == expQ2.data))
    else begin
      errorCount++;
      $error("ERROR t=%0t dac2 expected %h actual %h", $time, $sampled(expQ2), $sampled(dac2));
    end

endmodule

bind dualFilterDetector detector_checker u_checker (.*);

/* sim/tbDualFilterDetector.sv */
// checking lives in the bound checker; selects start on non-sample codes so syncs stay quiet
`timescale 1ns/1ps
`include "detector_settings.svh"

module tbDualFilterDetector import detectorPkg::*; ();

  logic                            clk = 1'b0;
  logic                            reset;
  logic                            symEn;
  logic                            sym2xEn;
  iqSample_t                       sample;
  logic [3:0]                      dac0Select;
  logic [3:0]                      dac1Select;
  logic [3:0]                      dac2Select;
  logic                            decision;
  logic signed [`METRIC_WIDTH-1:0] metric;
  logic                            symEnOut;
  logic                            sym2xEnOut;
  dacPort_t                        dac0;
  dacPort_t                        dac1;
  dacPort_t                        dac2;

  // rotation starts on metric, filter0 and an unused code
  logic [3:0]  selCodes [5] = '{`DAC_SEL_METRIC, `DAC_SEL_FILTER0, 4'd11, `DAC_SEL_I, `DAC_SEL_Q};
  int          widths [3] = '{18, 14, 12};
  logic [31:0] lfsrState = 32'd93;
  int          sentCount = 0;
  int          resultCount = 0;
  int          timeoutCount = 0;
  int          waitCycles;
  int          assertErrors;

  always #2 clk = ~clk;

  dualFilterDetector u_dut (.*);

  // results counted away from the active edge
  always @(negedge clk) begin
    if (!reset && symEnOut) resultCount++;
  end

  // galois form with taps 32 30 26 25
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  // one lfsr step per bit taken, then sign extended from width
  task automatic randomValue(input int width, output logic [`SAMPLE_WIDTH-1:0] value);
    logic signed [31:0] bits;
    bits = '0;
    for (int n = 0; n < width; n++) begin
      lfsrState = lfsrStep(lfsrState);
      bits = {bits[30:0], lfsrState[0]};
    end
    bits = (bits <<< (32 - width)) >>> (32 - width);
    value = bits[`SAMPLE_WIDTH-1:0];
  endtask

  // sym2xEn every 3 cycles and symEn with the second one
  task automatic sendSymbol(input iqSample_t first, input iqSample_t second);
    @(negedge clk);
    sym2xEn = 1'b1;
    symEn = 1'b0;
    sample = first;
    @(negedge clk);
    sym2xEn = 1'b0;
    @(negedge clk);
    @(negedge clk);
    sym2xEn = 1'b1;
    symEn = 1'b1;
    sample = second;
    sentCount++;
    @(negedge clk);
    sym2xEn = 1'b0;
    symEn = 1'b0;
    @(negedge clk);
  endtask

  task automatic randomSymbol(input int width);
    iqSample_t a;
    iqSample_t b;
    randomValue(width, a.i);
    randomValue(width, a.q);
    randomValue(width, b.i);
    randomValue(width, b.q);
    sendSymbol(a, b);
  endtask

  // conjugate taps of the wanted filter at full scale drive the metric into the rails
  task automatic toneSymbol(input bit tone, input bit negate);
    logic signed [`SAMPLE_WIDTH-1:0] c [4];
    c = '{`F0_C0RE, `F0_C0IM, `F0_C1RE, `F0_C1IM};
    if (!tone) begin
      c[1] = -c[1];
      c[3] = -c[3];
    end
    if (negate) begin
      foreach (c[n]) c[n] = -c[n];
    end
    sendSymbol('{i: c[0], q: c[1]}, '{i: c[2], q: c[3]});
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    reset = 1'b1;
    symEn = 1'b0;
    sym2xEn = 1'b0;
    sample = '0;
    dac0Select = selCodes[0];
    dac1Select = selCodes[1];
    dac2Select = selCodes[2];
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (5) @(negedge clk);

    // random symbols over three amplitude ranges while the selects rotate
    for (int phase = 0; phase < 10; phase++) begin
      dac0Select = selCodes[phase % 5];
      dac1Select = selCodes[(phase + 1) % 5];
      dac2Select = selCodes[(phase + 2) % 5];
      for (int k = 0; k < 4; k++) randomSymbol(widths[phase % 3]);
    end

    // saturation bursts for both tones and both signs
    for (int tone = 0; tone < 2; tone++) begin
      for (int k = 0; k < 4; k++) toneSymbol(tone[0], k[0]);
    end

    // result counter moves on the falling edge, so poll on the rising one
    waitCycles = 0;
    while (resultCount < sentCount && waitCycles < 20) begin
      @(posedge clk);
      waitCycles++;
    end
    if (resultCount < sentCount) begin
      timeoutCount++;
      $display("timeout: only %0d of %0d symbols produced a result", resultCount, sentCount);
    end

    // sym2xEnOut and the metric dac sync trail the last symEnOut by up to 3 cycles
    repeat (4) @(negedge clk);

    assertErrors = u_dut.u_checker.errorCount;
    $display("symbols sent %0d, results seen %0d, assertion errors %0d, timeouts %0d",
             sentCount, resultCount, assertErrors, timeoutCount);
    if (assertErrors == 0 && timeoutCount == 0 && resultCount == sentCount) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
design/detectorPkg.sv
design/matchedFilter.sv
design/energyCompare.sv
design/dacMonitor.sv
design/dualFilterDetector.sv
sim/detector_checker.sv
sim/tbDualFilterDetector.sv
